//--- common/irig_pkg.sv
`default_nettype none

package irig_pkg;

    // APB register map
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;
    localparam logic [APB_AW-1:0] ADDR_CTRL = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_TIME = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_DATE = 4'h8;

    localparam int FRAME_BITS = 100;
    localparam int BIT_IDX_W  = 7;
    localparam int BIT_TICKS  = 100;   // one tick is 0.1 ms, so a bit is 10 ms
    localparam int TICK_W     = 7;

    localparam int W_ZERO = 20;        // pwm high time in ticks
    localparam int W_ONE  = 50;
    localparam int W_MARK = 80;

    localparam int SYM_W = 2;
    localparam logic [SYM_W-1:0] SYM_ZERO = 2'd0;
    localparam logic [SYM_W-1:0] SYM_ONE  = 2'd1;
    localparam logic [SYM_W-1:0] SYM_MARK = 2'd2;

    // seconds of day is hours*3600 + minutes*60 + seconds, at most 86399
    localparam int SBS_W     = 17;
    localparam int SBS_STEPS = 12;
    localparam logic [SBS_STEPS-1:0] HRS_WEIGHT = 12'd3600;
    localparam logic [SBS_STEPS-1:0] MIN_WEIGHT = 12'd60;

    // first bit index of each field; tens digit sits TENS_OFS above the units digit
    localparam int POS_SEC    = 1;
    localparam int POS_MIN    = 10;
    localparam int POS_HRS    = 20;
    localparam int POS_DAY    = 30;
    localparam int POS_YRS    = 50;
    localparam int POS_SBS_LO = 80;
    localparam int POS_SBS_HI = 90;
    localparam int TENS_OFS   = 5;
    localparam int HUND_OFS   = 10;    // day hundreds skips the P4 marker

    typedef struct packed {
        logic [11:0] spare;
        logic [1:0]  hrs_t;
        logic [3:0]  hrs_u;
        logic [2:0]  min_t;
        logic [3:0]  min_u;
        logic [2:0]  sec_t;
        logic [3:0]  sec_u;
    } time_bcd_t;

    typedef union packed {
        logic [31:0] raw;
        time_bcd_t   bcd;
    } time_word_u;

    typedef struct packed {
        logic [13:0] spare;
        logic [3:0]  yr_t;
        logic [3:0]  yr_u;
        logic [1:0]  day_h;
        logic [3:0]  day_t;
        logic [3:0]  day_u;
    } date_bcd_t;

    typedef union packed {
        logic [31:0] raw;
        date_bcd_t   bcd;
    } date_word_u;

endpackage

`default_nettype wire

//--- hw/irig_apb_regs.sv
`default_nettype none

module irig_apb_regs (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire  [irig_pkg::APB_AW-1:0]    paddr,
    input  wire  [irig_pkg::APB_DW-1:0]    pwdata,
    output logic [irig_pkg::APB_DW-1:0]    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           enable,
    output irig_pkg::time_word_u           time_word,
    output irig_pkg::date_word_u           date_word
);
    import irig_pkg::*;

    logic acc_phase;
    logic hit_ctrl;
    logic hit_time;
    logic hit_date;

    assign acc_phase = psel && penable;
    assign hit_ctrl  = (paddr == ADDR_CTRL);
    assign hit_time  = (paddr == ADDR_TIME);
    assign hit_date  = (paddr == ADDR_DATE);

    assign pready  = 1'b1;    // every access completes without wait states
    assign pslverr = acc_phase && !(hit_ctrl || hit_time || hit_date);

    // writes land on the edge that closes the access phase
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            enable        <= 1'b0;
            time_word.raw <= '0;
            date_word.raw <= '0;
        end
        else if (acc_phase && pwrite)
        begin
            if (hit_ctrl)
                enable <= pwdata[0];
            if (hit_time)
                time_word.raw <= pwdata;
            if (hit_date)
                date_word.raw <= pwdata;
        end
    end

    // read mux, unmapped addresses return zero
    always_comb
    begin
        prdata = '0;
        if (psel && !pwrite)
        begin
            if (hit_ctrl)
                prdata = {{(APB_DW-1){1'b0}}, enable};   // other CTRL bits read as zero
            else if (hit_time)
                prdata = time_word.raw;
            else if (hit_date)
                prdata = date_word.raw;
        end
    end

endmodule

`default_nettype wire

//--- hw/irig_frame/irig_sbs_calc.sv
`default_nettype none

module irig_sbs_calc (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           sbs_start,
    input  wire  [4:0]                    hrs_bin,
    input  wire  [5:0]                    min_bin,
    input  wire  [5:0]                    sec_bin,
    output logic [irig_pkg::SBS_W-1:0]    sbs,
    output logic                          sbs_done
);
    import irig_pkg::*;

    logic                         busy;
    logic [$clog2(SBS_STEPS)-1:0] step;      // weight bit under test
    logic [SBS_W-1:0]             hrs_op;    // shifted left once per step
    logic [SBS_W-1:0]             min_op;
    logic [SBS_W-1:0]             add_hrs;
    logic [SBS_W-1:0]             add_min;

    assign add_hrs = HRS_WEIGHT[step] ? hrs_op : '0;
    assign add_min = MIN_WEIGHT[step] ? min_op : '0;

    // one load cycle then twelve add cycles, done lands 13 clocks after start
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            busy     <= 1'b0;
            step     <= '0;
            sbs_done <= 1'b0;
        end
        else
        begin
            sbs_done <= 1'b0;
            if (sbs_start)
            begin
                busy <= 1'b1;
                step <= '0;
            end
            else if (busy)
            begin
                step <= step + 1'b1;
                if (step == ($clog2(SBS_STEPS))'(SBS_STEPS - 1))
                begin
                    busy     <= 1'b0;
                    step     <= '0;
                    sbs_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sbs_start)
        begin
            sbs    <= SBS_W'(sec_bin);   // seconds seed the accumulator
            hrs_op <= SBS_W'(hrs_bin);
            min_op <= SBS_W'(min_bin);
        end
        else if (busy)
        begin
            sbs    <= sbs + add_hrs + add_min;
            hrs_op <= hrs_op << 1;
            min_op <= min_op << 1;
        end
    end

endmodule

`default_nettype wire

//--- hw/irig_frame/irig_frame_builder.sv
`default_nettype none

module irig_frame_builder (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              frame_start,
    input  wire  [irig_pkg::BIT_IDX_W-1:0]   bit_idx,
    input  wire  irig_pkg::time_word_u       time_word,
    input  wire  irig_pkg::date_word_u       date_word,
    output logic [irig_pkg::SYM_W-1:0]       sym_kind
);
    import irig_pkg::*;

    logic [3:0]            sec_u, min_u, hrs_u, day_u, day_t, yr_u, yr_t;
    logic [2:0]            sec_t, min_t;
    logic [1:0]            hrs_t, day_h;
    logic [6:0]            sec_bin7, min_bin7, hrs_bin7;
    logic [SBS_W-1:0]      sbs_new;
    logic [SBS_W-1:0]      sbs_hold;   // previous frame's value until the new one is ready
    logic                  sbs_done;
    logic [FRAME_BITS-1:0] data_bits;
    logic                  is_marker;

    // tens*10 + units as (tens << 3) + (tens << 1) + units
    function automatic logic [6:0] bcd_to_bin(input logic [3:0] tens, input logic [3:0] units);
        return {tens, 3'b000} + {2'b00, tens, 1'b0} + {3'b000, units};
    endfunction

    // converted from the live word, it is the same value being latched on this edge
    assign sec_bin7 = bcd_to_bin({1'b0, time_word.bcd.sec_t}, time_word.bcd.sec_u);
    assign min_bin7 = bcd_to_bin({1'b0, time_word.bcd.min_t}, time_word.bcd.min_u);
    assign hrs_bin7 = bcd_to_bin({2'b00, time_word.bcd.hrs_t}, time_word.bcd.hrs_u);

    irig_sbs_calc i_sbs (
        .clk       (clk),
        .rst       (rst),
        .sbs_start (frame_start),
        .hrs_bin   (hrs_bin7[4:0]),
        .min_bin   (min_bin7[5:0]),
        .sec_bin   (sec_bin7[5:0]),
        .sbs       (sbs_new),
        .sbs_done  (sbs_done)
    );

    always_ff @(posedge clk)
    begin
        if (frame_start)
        begin
            sec_u <= time_word.bcd.sec_u;
            sec_t <= time_word.bcd.sec_t;
            min_u <= time_word.bcd.min_u;
            min_t <= time_word.bcd.min_t;
            hrs_u <= time_word.bcd.hrs_u;
            hrs_t <= time_word.bcd.hrs_t;
            day_u <= date_word.bcd.day_u;
            day_t <= date_word.bcd.day_t;
            day_h <= date_word.bcd.day_h;
            yr_u  <= date_word.bcd.yr_u;
            yr_t  <= date_word.bcd.yr_t;
        end
        if (sbs_done)
            sbs_hold <= sbs_new;
    end

    // data bit per index, LSB first; control bits 60 to 79 stay zero
    always_comb
    begin
        data_bits = '0;
        data_bits[POS_SEC +: 4]             = sec_u;
        data_bits[POS_SEC + TENS_OFS +: 3]  = sec_t;
        data_bits[POS_MIN +: 4]             = min_u;
        data_bits[POS_MIN + TENS_OFS +: 3]  = min_t;
        data_bits[POS_HRS +: 4]             = hrs_u;
        data_bits[POS_HRS + TENS_OFS +: 2]  = hrs_t;
        data_bits[POS_DAY +: 4]             = day_u;
        data_bits[POS_DAY + TENS_OFS +: 4]  = day_t;
        data_bits[POS_DAY + HUND_OFS +: 2]  = day_h;
        data_bits[POS_YRS +: 4]             = yr_u;
        data_bits[POS_YRS + TENS_OFS +: 4]  = yr_t;
        data_bits[POS_SBS_LO +: 9]          = sbs_hold[8:0];
        data_bits[POS_SBS_HI +: 8]          = sbs_hold[16:9];
    end

    // reference marker at 0, position markers at every index ending in 9
    assign is_marker = (bit_idx == '0) || ((bit_idx % 10) == 9);

    always_comb
    begin
        if (is_marker)
            sym_kind = SYM_MARK;
        else if (data_bits[bit_idx])
            sym_kind = SYM_ONE;
        else
            sym_kind = SYM_ZERO;
    end

endmodule

`default_nettype wire

//--- hw/irig_tx/irig_symbol_gen.sv
`default_nettype none

module irig_symbol_gen #(
    parameter int CLK_DIV = 5000
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              enable,
    input  wire  [irig_pkg::SYM_W-1:0]       sym_kind,
    output logic [irig_pkg::BIT_IDX_W-1:0]   bit_idx,
    output logic                             frame_start,
    output logic                             pwm,
    output logic                             manch
);
    import irig_pkg::*;

    localparam int PRESC_W = $clog2(CLK_DIV + 1);

    logic [PRESC_W-1:0] presc;
    logic               tick;
    logic               running;      // set by the first tick after enable rises
    logic [TICK_W-1:0]  tick_cnt;
    logic               bit_end;
    logic               frame_end;
    logic [TICK_W-1:0]  high_ticks;

    assign tick        = enable && (presc == PRESC_W'(CLK_DIV - 1));
    assign bit_end     = (tick_cnt == TICK_W'(BIT_TICKS - 1));
    assign frame_end   = bit_end && (bit_idx == BIT_IDX_W'(FRAME_BITS - 1));
    assign frame_start = tick && (!running || frame_end);

    always_ff @(posedge clk)
    begin
        if (!rst || !enable || tick)
            presc <= '0;
        else
            presc <= presc + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst || !enable)
        begin
            running  <= 1'b0;
            tick_cnt <= '0;
            bit_idx  <= '0;
        end
        else if (tick)
        begin
            running <= 1'b1;
            if (frame_start)
            begin
                tick_cnt <= '0;
                bit_idx  <= '0;
            end
            else if (bit_end)
            begin
                tick_cnt <= '0;
                bit_idx  <= bit_idx + 1'b1;
            end
            else
                tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_comb
    begin
        case (sym_kind)
            SYM_ONE:  high_ticks = TICK_W'(W_ONE);
            SYM_MARK: high_ticks = TICK_W'(W_MARK);
            default:  high_ticks = TICK_W'(W_ZERO);
        endcase
    end

    // outputs trail the counters by one clock, so every edge keeps its spacing
    always_ff @(posedge clk)
    begin
        if (!rst || !enable || !running)
        begin
            pwm   <= 1'b0;
            manch <= 1'b0;
        end
        else
        begin
            pwm   <= (tick_cnt < high_ticks);
            manch <= (tick_cnt < TICK_W'(BIT_TICKS / 2)) ^ (sym_kind == SYM_ZERO);  // zero is low-high
        end
    end

endmodule

`default_nettype wire

//--- hw/irig_b_top.sv
`default_nettype none

module irig_b_top #(
    parameter int CLK_DIV = 5000       // clk cycles per 0.1 ms tick at 50 MHz
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire  [irig_pkg::APB_AW-1:0]    paddr,
    input  wire  [irig_pkg::APB_DW-1:0]    pwdata,
    output logic [irig_pkg::APB_DW-1:0]    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           pwm,
    output logic                           manch
);
    import irig_pkg::*;

    logic                 enable;
    time_word_u           time_word;
    date_word_u           date_word;
    logic [BIT_IDX_W-1:0] bit_idx;
    logic                 frame_start;
    logic [SYM_W-1:0]     sym_kind;

    irig_apb_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .enable    (enable),
        .time_word (time_word),
        .date_word (date_word)
    );

    // frame content, looked up by the symbol generator's bit index
    irig_frame_builder i_frame (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .bit_idx     (bit_idx),
        .time_word   (time_word),
        .date_word   (date_word),
        .sym_kind    (sym_kind)
    );

    irig_symbol_gen #(
        .CLK_DIV (CLK_DIV)
    ) i_symgen (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .sym_kind    (sym_kind),
        .bit_idx     (bit_idx),
        .frame_start (frame_start),
        .pwm         (pwm),
        .manch       (manch)
    );

endmodule

`default_nettype wire

//--- tb/irig_b_sva.sv
`default_nettype none

module irig_b_sva (
    input wire clk,
    input wire rst,
    input wire psel,
    input wire penable,
    input wire pready,
    input wire pslverr,
    input wire enable,
    input wire pwm,
    input wire manch
);
    timeunit 1ns;
    timeprecision 100ps;

    // the slave never inserts wait states
    assert property (@(posedge clk) disable iff (!rst) pready)
        else $error("pready went low");

    assert property (@(posedge clk) disable iff (!rst) pslverr |-> (psel && penable))
        else $error("pslverr raised outside an access phase");

    // outputs are forced low one clock after enable is seen low
    assert property (@(posedge clk) disable iff (!rst) !enable |=> (!pwm && !manch))
        else $error("pwm or manch active while enable is low");

endmodule

bind irig_b_top irig_b_sva i_sva (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .pslverr (pslverr),
    .enable  (enable),
    .pwm     (pwm),
    .manch   (manch)
);

`default_nettype wire

//--- tb/tb_irig_b.sv
`default_nettype none

module tb_irig_b;
    timeunit 1ns;
    timeprecision 100ps;
    import irig_pkg::*;

    localparam int CLK_DIV     = 4;
    localparam int IN_DLY      = 5;                       // drive delay after the rising edge
    localparam int BIT_CLKS    = BIT_TICKS * CLK_DIV;
    localparam int FRAME_CLKS  = FRAME_BITS * BIT_CLKS;
    localparam int APB_TIMEOUT = 16;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              pwm;
    logic              manch;

    logic              mon_on;                            // capture runs only while set
    logic [SYM_W+1:0]  sym_q[$];                          // {symbol, manch early, manch late}
    int                flush_req = 0;
    int                flush_seen = 0;
    int                cmp_idx = 0;
    int                frames_checked = 0;
    time_word_u        next_time;
    date_word_u        next_date;
    time_word_u        cur_time;
    date_word_u        cur_date;

    logic              pwm_prev;
    logic              cap_busy = 1'b0;
    int                cap_cnt;
    int                high_cnt;
    int                ticks;
    logic              manch_a;
    logic              manch_b;
    logic [SYM_W-1:0]  cap_sym;
    logic [SYM_W+1:0]  entry;
    logic [SYM_W-1:0]  exp_sym;

    irig_b_top #(
        .CLK_DIV (CLK_DIV)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .pwm     (pwm),
        .manch   (manch)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_rdata(input string name, input logic [APB_DW-1:0] got,
                               input logic [APB_DW-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("[FAIL] prdata %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    task automatic check_symbol(input string name, input logic [SYM_W-1:0] got,
                                input logic [SYM_W-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    function automatic time_word_u make_time(input int h, input int m, input int s,
                                             input logic [11:0] spare);
        time_word_u w;
        w.bcd.spare = spare;
        w.bcd.hrs_t = 2'(h / 10);
        w.bcd.hrs_u = 4'(h % 10);
        w.bcd.min_t = 3'(m / 10);
        w.bcd.min_u = 4'(m % 10);
        w.bcd.sec_t = 3'(s / 10);
        w.bcd.sec_u = 4'(s % 10);
        return w;
    endfunction

    function automatic date_word_u make_date(input int day, input int yr,
                                             input logic [13:0] spare);
        date_word_u w;
        w.bcd.spare = spare;
        w.bcd.yr_t  = 4'(yr / 10);
        w.bcd.yr_u  = 4'(yr % 10);
        w.bcd.day_h = 2'(day / 100);
        w.bcd.day_t = 4'((day / 10) % 10);
        w.bcd.day_u = 4'(day % 10);
        return w;
    endfunction

    // expected symbol of one frame position, built from decimal time values
    function automatic logic [SYM_W-1:0] ref_symbol(input time_word_u t, input date_word_u d,
                                                     input int idx);
        logic [FRAME_BITS-1:0] bits;
        logic [SBS_W-1:0]      sbs;
        int                    secs;
        int                    mins;
        int                    hrs;
        secs = 10 * int'(t.bcd.sec_t) + int'(t.bcd.sec_u);
        mins = 10 * int'(t.bcd.min_t) + int'(t.bcd.min_u);
        hrs  = 10 * int'(t.bcd.hrs_t) + int'(t.bcd.hrs_u);
        sbs  = SBS_W'(hrs * 3600 + mins * 60 + secs);
        bits = '0;
        for (int i = 0; i < 4; i++)
        begin
            bits[POS_SEC + i]     = t.bcd.sec_u[i];
            bits[POS_MIN + i]     = t.bcd.min_u[i];
            bits[POS_HRS + i]     = t.bcd.hrs_u[i];
            bits[POS_DAY + i]     = d.bcd.day_u[i];
            bits[POS_DAY + 5 + i] = d.bcd.day_t[i];
            bits[POS_YRS + i]     = d.bcd.yr_u[i];
            bits[POS_YRS + 5 + i] = d.bcd.yr_t[i];
        end
        for (int i = 0; i < 3; i++)
        begin
            bits[POS_SEC + 5 + i] = t.bcd.sec_t[i];
            bits[POS_MIN + 5 + i] = t.bcd.min_t[i];
        end
        for (int i = 0; i < 2; i++)
        begin
            bits[POS_HRS + 5 + i]  = t.bcd.hrs_t[i];
            bits[POS_DAY + 10 + i] = d.bcd.day_h[i];   // hundreds of days after the P4 marker
        end
        for (int i = 0; i < 9; i++)
            bits[POS_SBS_LO + i] = sbs[i];
        for (int i = 0; i < 8; i++)
            bits[POS_SBS_HI + i] = sbs[9 + i];
        if (idx == 0 || idx % 10 == 9)
            return SYM_MARK;
        return bits[idx] ? SYM_ONE : SYM_ZERO;
    endfunction

    task automatic apb_xfer(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata);
        int   waited;
        logic exp_err;
        waited  = 0;
        exp_err = !(addr == ADDR_CTRL || addr == ADDR_TIME || addr == ADDR_DATE);
        psel    = 1'b1;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #IN_DLY;
        penable = 1'b1;
        @(negedge clk);
        while (!pready)
        begin
            waited++;
            if (waited > APB_TIMEOUT)
                fail_now("APB access timed out waiting for pready");
            @(negedge clk);
        end
        rdata = prdata;                                   // sampled mid access phase
        check_level("pslverr", pslverr, exp_err);
        @(posedge clk);
        #IN_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        logic [APB_DW-1:0] unused_rd;
        apb_xfer(1'b1, addr, data, unused_rd);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        apb_xfer(1'b0, addr, '0, data);
    endtask

    // returns once the compare process has passed the given frame count and bit
    task automatic wait_frames(input int frames, input int bit_pos);
        int clocks;
        clocks = 0;
        while (frames_checked < frames || (frames_checked == frames && cmp_idx < bit_pos))
        begin
            @(posedge clk);
            #IN_DLY;
            clocks++;
            if (clocks > 3 * FRAME_CLKS)
                fail_now($sformatf("timed out waiting for frame %0d bit %0d", frames, bit_pos));
        end
    endtask

    // measures each pwm pulse from its rising edge, sampling at the falling clock edge
    always @(negedge clk)
    begin
        if (!mon_on)
            cap_busy = 1'b0;
        else if (pwm && !pwm_prev)
        begin
            if (cap_busy)
                fail_now("pwm rose again before the previous bit ended");
            cap_busy = 1'b1;
            cap_cnt  = 0;
            high_cnt = 1;
        end
        else if (cap_busy)
        begin
            cap_cnt++;
            if (pwm)
                high_cnt++;
            if (cap_cnt == BIT_CLKS / 4)
                manch_a = manch;
            if (cap_cnt == 3 * BIT_CLKS / 4)
                manch_b = manch;
            if (cap_cnt == BIT_CLKS - 1)
            begin
                ticks = high_cnt / CLK_DIV;
                if (high_cnt % CLK_DIV != 0)
                    fail_now($sformatf("pwm high for %0d clocks, not whole ticks", high_cnt));
                if (ticks == W_ZERO)
                    cap_sym = SYM_ZERO;
                else if (ticks == W_ONE)
                    cap_sym = SYM_ONE;
                else if (ticks == W_MARK)
                    cap_sym = SYM_MARK;
                else
                    fail_now($sformatf("pwm high for %0d ticks, no symbol has that width", ticks));
                sym_q.push_back({cap_sym, manch_a, manch_b});
                cap_busy = 1'b0;
            end
        end
        pwm_prev = pwm;
    end

    // compares captured bits with the reference frame, new words take effect at bit 0
    always @(posedge clk)
    begin
        if (flush_seen != flush_req)
        begin
            flush_seen = flush_req;
            sym_q.delete();
            cmp_idx = 0;
        end
        else if (sym_q.size() > 0)
        begin
            entry = sym_q.pop_front();
            if (cmp_idx == 0)
            begin
                cur_time = next_time;
                cur_date = next_date;
            end
            exp_sym = ref_symbol(cur_time, cur_date, cmp_idx);
            check_symbol($sformatf("pwm symbol at bit %0d", cmp_idx), entry[SYM_W+1:2], exp_sym);
            check_level($sformatf("manch first half at bit %0d", cmp_idx), entry[1],
                        exp_sym != SYM_ZERO);
            check_level($sformatf("manch second half at bit %0d", cmp_idx), entry[0],
                        exp_sym == SYM_ZERO);
            if (cmp_idx == FRAME_BITS - 1)
            begin
                cmp_idx = 0;
                frames_checked++;
            end
            else
                cmp_idx++;
        end
    end

    initial
    begin
        time_word_u        t_a;
        time_word_u        t_b;
        time_word_u        t_c;
        date_word_u        d_a;
        date_word_u        d_b;
        date_word_u        d_c;
        logic [APB_DW-1:0] rd;
        int                base;
        void'($urandom(89));
        rst       = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        mon_on    = 1'b0;
        t_a       = make_time(13, 47, 59, 12'hA5C);       // spare bits are stored but not sent
        d_a       = make_date(256, 24, 14'h2B1);
        t_b       = make_time(7, 5, 3, 12'h000);
        d_b       = make_date(45, 9, 14'h000);
        t_c       = make_time(23, 59, 59, 12'h000);       // largest seconds of day
        d_c       = make_date(366, 99, 14'h000);
        next_time = t_a;
        next_date = d_a;
        repeat (16) @(posedge clk);
        #IN_DLY;
        rst = 1'b1;

        apb_write(ADDR_TIME, t_a.raw);
        apb_write(ADDR_DATE, d_a.raw);
        apb_write(ADDR_CTRL, 32'hFFFF_FFFE);
        apb_read(ADDR_TIME, rd);
        check_rdata("TIME readback", rd, t_a.raw);
        apb_read(ADDR_DATE, rd);
        check_rdata("DATE readback", rd, d_a.raw);
        apb_read(ADDR_CTRL, rd);
        check_rdata("CTRL readback", rd, 32'h0);
        apb_write(4'hC, 32'hDEAD_BEEF);
        apb_read(4'hC, rd);
        check_rdata("unmapped readback", rd, 32'h0);
        apb_read(ADDR_TIME, rd);
        check_rdata("TIME after unmapped write", rd, t_a.raw);

        mon_on = 1'b1;
        apb_write(ADDR_CTRL, 32'h0000_0005);
        apb_read(ADDR_CTRL, rd);
        check_rdata("CTRL readback", rd, 32'h1);
        wait_frames(1, 0);

        // mid-frame write shows up one frame later
        wait_frames(1, 40);
        apb_write(ADDR_TIME, t_b.raw);
        apb_write(ADDR_DATE, d_b.raw);
        next_time = t_b;
        next_date = d_b;
        wait_frames(3, 0);

        wait_frames(3, 30);
        mon_on = 1'b0;
        apb_write(ADDR_CTRL, 32'h0);
        @(negedge clk);
        @(negedge clk);
        check_level("pwm after disable", pwm, 1'b0);
        check_level("manch after disable", manch, 1'b0);
        @(posedge clk);
        #IN_DLY;
        flush_req++;
        next_time = t_c;
        next_date = d_c;
        apb_write(ADDR_TIME, t_c.raw);
        apb_write(ADDR_DATE, d_c.raw);
        mon_on = 1'b1;
        apb_write(ADDR_CTRL, 32'h1);
        wait_frames(4, 0);

        base = 4;
        for (int n = 0; n < 3; n++)
        begin
            t_b = make_time($urandom_range(23), $urandom_range(59), $urandom_range(59),
                            12'($urandom));
            d_b = make_date($urandom_range(366, 1), $urandom_range(99), 14'($urandom));
            wait_frames(base, 40);
            apb_write(ADDR_TIME, t_b.raw);
            apb_write(ADDR_DATE, d_b.raw);
            next_time = t_b;
            next_date = d_b;
            base += 2;
            wait_frames(base, 0);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- irig_b_gen.f
common/irig_pkg.sv
hw/irig_apb_regs.sv
hw/irig_frame/irig_sbs_calc.sv
hw/irig_frame/irig_frame_builder.sv
hw/irig_tx/irig_symbol_gen.sv
hw/irig_b_top.sv
tb/irig_b_sva.sv
tb/tb_irig_b.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_irig_b \
    -f irig_b_gen.f -o sim_irig_b
if [ $? -ne 0 ]; then
    echo "verilator build step returned an error"
    exit 1
fi

./obj_dir/sim_irig_b
status=$?
if [ $status -ne 0 ]; then
    echo "simulation run exited with status $status"
    exit $status
fi
exit 0
